// ==== logic/dmem_macros.svh ====
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// byte address bits decoded by the data RAM
// word index = DMEM_ADDR_BITS - 2
`define DMEM_ADDR_BITS 12

// UART transmit register, full 32-bit match
`define DMEM_UART_ADDR 32'h1000_0000

`endif

// ==== logic/mem_types_pkg.sv ====
`default_nettype none

`include "dmem_macros.svh"

package mem_types_pkg;

   typedef enum logic [1:0] {
      SIZE_WORD = 2'd0,
      SIZE_BYTE = 2'd1,
      SIZE_HALF = 2'd2
   } access_size_e;   // 3 behaves as word

   typedef struct packed {
      logic [31-`DMEM_ADDR_BITS:0] upper;
      logic [`DMEM_ADDR_BITS-3:0]  word_idx;
      logic [1:0]                  offset;
   } addr_fields_t;

   // raw view for the MMIO compare, field view for RAM addressing
   typedef union packed {
      logic [31:0]  raw;
      addr_fields_t fields;
   } mem_addr_u;

   // mask store data to the access size, then move it up to its byte lane
   function automatic logic [31:0] align_store(input logic [31:0] data,
                                               input access_size_e size,
                                               input logic [1:0] offset);
      logic [31:0] masked;
      case (size)
         SIZE_BYTE: masked = {24'h0, data[7:0]};
         SIZE_HALF: masked = {16'h0, data[15:0]};
         default:   masked = data;
      endcase
      return masked << {offset, 3'b000};
   endfunction

endpackage

`default_nettype wire

// ==== logic/wb_types_pkg.sv ====
`default_nettype none

package wb_types_pkg;

   typedef logic [4:0] reg_idx_t;

   // control that travels one cycle alongside the RAM read
   typedef struct packed {
      reg_idx_t                    rd;
      logic                        reg_we;       // already qualified by run
      logic                        mem_to_reg;
      logic                        unsigned_flag;
      mem_types_pkg::access_size_e size;
      logic [1:0]                  offset;
   } wb_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pipeline memory request, as seen by the RAM, MMIO and write-back blocks
interface mem_req_if;

   mem_types_pkg::mem_addr_u    addr;
   mem_types_pkg::access_size_e size;
   logic [31:0]                 wdata;
   logic                        we;
   logic                        unsigned_flag;
   logic                        mem_to_reg;

   modport src (output addr, size, wdata, we, unsigned_flag, mem_to_reg);

   modport ram (input addr, size, wdata, we);

   modport mmio (input addr, size, wdata, we);

   // load side only needs offset and size, wdata is not used here
   modport wb (input addr, size, unsigned_flag, mem_to_reg);

endinterface

`default_nettype wire

// ==== logic/simple_dualportram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_macros.svh"

module simple_dualportram (
   input  logic                         clk,
   input  logic [`DMEM_ADDR_BITS-3:0]   waddress,
   input  logic [7:0]                   din,
   input  logic                         we,
   input  logic [`DMEM_ADDR_BITS-3:0]   raddress,
   output logic [7:0]                   dout
);

   logic [7:0] mem [2**(`DMEM_ADDR_BITS-2)];

   always_ff @(posedge clk) begin
      if (we)
         mem[waddress] <= din;
      dout <= mem[raddress];   // read-before-write on a collision
   end

endmodule

`default_nettype wire

// ==== logic/byte_lane_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_macros.svh"

module byte_lane_ram (
   input  logic        clk,
   input  logic        rst,
   mem_req_if.ram      req,
   input  logic        uart_sel,
   input  logic [31:0] addr_b,
   input  logic [31:0] din_b,
   input  logic        we_b,
   input  logic        oe_b,
   output logic [31:0] ram_rdata,
   output logic [31:0] dout_b
);

   localparam int WIDX = `DMEM_ADDR_BITS - 2;

   logic [31:0]     lane_data;
   logic [3:0]      lane_en;
   logic            pipe_wr;

   logic [WIDX-1:0] waddr;
   logic [WIDX-1:0] raddr;
   logic [31:0]     wr_data;
   logic [3:0]      wr_en;

   assign lane_data = mem_types_pkg::align_store(req.wdata, req.size,
                                                 req.addr.fields.offset);

   always_comb begin
      case (req.size)
         mem_types_pkg::SIZE_BYTE: lane_en = 4'b0001 << req.addr.fields.offset;
         mem_types_pkg::SIZE_HALF: lane_en = 4'b0011 << req.addr.fields.offset;
         default:                  lane_en = 4'b1111;
      endcase
   end

   // stores aimed at the UART never reach the RAM
   assign pipe_wr = req.we && !uart_sel;

   // pipeline store has priority, a colliding port B write is dropped
   always_comb begin
      if (rst) begin
         waddr   = '0;
         wr_data = '0;
         wr_en   = 4'b0000;
      end else if (pipe_wr) begin
         waddr   = req.addr.fields.word_idx;
         wr_data = lane_data;
         wr_en   = lane_en;
      end else if (we_b) begin
         waddr   = addr_b[`DMEM_ADDR_BITS-1:2];
         wr_data = din_b;
         wr_en   = 4'b1111;
      end else begin
         waddr   = '0;
         wr_data = '0;
         wr_en   = 4'b0000;
      end
   end

   assign raddr = oe_b ? addr_b[`DMEM_ADDR_BITS-1:2] : req.addr.fields.word_idx;

   for (genvar i = 0; i < 4; i++) begin : g_lane
      simple_dualportram u_ram (
         .clk      (clk),
         .waddress (waddr),
         .din      (wr_data[8*i +: 8]),
         .we       (wr_en[i]),
         .raddress (raddr),
         .dout     (ram_rdata[8*i +: 8])
      );
   end

   assign dout_b = ram_rdata;   // same word, host and pipeline share the read

endmodule

`default_nettype wire

// ==== logic/mmio_uart_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_macros.svh"

module mmio_uart_port (
   input  logic        clk,
   input  logic        rst,
   mem_req_if.mmio     req,
   output logic        uart_sel,
   output logic        uart_hit_r,
   output logic [31:0] uart_dout,
   output logic        uart_we
);

   logic uart_store;

   assign uart_sel   = (req.addr.raw == `DMEM_UART_ADDR);
   assign uart_store = req.we && uart_sel;

   always_ff @(posedge clk) begin
      if (rst) begin
         uart_we    <= 1'b0;
         uart_hit_r <= 1'b0;
      end else begin
         uart_we    <= uart_store;   // one-cycle strobe
         uart_hit_r <= uart_sel;     // load from here reads zero
      end
   end

   // holds until the next UART store
   always_ff @(posedge clk) begin
      if (uart_store)
         uart_dout <= mem_types_pkg::align_store(req.wdata, req.size,
                                                 req.addr.fields.offset);
   end

endmodule

`default_nettype wire

// ==== logic/load_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_writeback (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   mem_req_if.wb                  req,
   input  wb_types_pkg::reg_idx_t rd_in,
   input  logic                   reg_we_in,
   input  logic [31:0]            alu_result,
   input  logic [31:0]            ram_rdata,
   input  logic                   uart_hit_r,
   output logic [31:0]            reg_wdata,
   output logic                   reg_we_out,
   output wb_types_pkg::reg_idx_t reg_rd
);

   wb_types_pkg::wb_ctrl_t ctrl_r;
   logic [31:0]            alu_r;
   logic [23:0]            fill;
   logic [31:0]            shifted;
   logic [31:0]            loaded;
   logic                   sgn;

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_r <= '0;
      end else begin
         ctrl_r <= '{rd:            rd_in,
                     reg_we:        run && reg_we_in,
                     mem_to_reg:    req.mem_to_reg,
                     unsigned_flag: req.unsigned_flag,
                     size:          req.size,
                     offset:        req.addr.fields.offset};
      end
   end

   always_ff @(posedge clk) begin
      alu_r <= alu_result;
   end

   always_comb begin
      fill = (ctrl_r.unsigned_flag || !ram_rdata[31]) ? 24'h00_0000 : 24'hff_ffff;
      case (ctrl_r.offset)
         2'd1:    shifted = {fill[7:0],  ram_rdata[31:8]};
         2'd2:    shifted = {fill[15:0], ram_rdata[31:16]};
         2'd3:    shifted = {fill,       ram_rdata[31:24]};
         default: shifted = ram_rdata;
      endcase

      // extend to the access size
      case (ctrl_r.size)
         mem_types_pkg::SIZE_BYTE: begin
            sgn    = !ctrl_r.unsigned_flag && shifted[7];
            loaded = {{24{sgn}}, shifted[7:0]};
         end
         mem_types_pkg::SIZE_HALF: begin
            sgn    = !ctrl_r.unsigned_flag && shifted[15];
            loaded = {{16{sgn}}, shifted[15:0]};
         end
         default: begin
            sgn    = 1'b0;
            loaded = shifted;
         end
      endcase

      if (uart_hit_r)
         loaded = '0;   // UART register is write only
   end

   assign reg_wdata  = ctrl_r.mem_to_reg ? loaded : alu_r;
   assign reg_we_out = ctrl_r.reg_we;
   assign reg_rd     = ctrl_r.rd;

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory (
   input  wire         clk,
   input  wire         rst,
   input  wire         run,

   // host port
   input  wire  [31:0] addr_b,
   input  wire  [31:0] din_b,
   input  wire         we_b,
   input  wire         oe_b,
   output logic [31:0] dout_b,

   // pipeline request
   input  wire  [31:0] addr,
   input  wire  [1:0]  bytes,
   input  wire  [31:0] wdata,
   input  wire         we,
   input  wire         mem_to_reg_in,
   input  wire  [31:0] alu_result,
   input  wire  [4:0]  rd_in,
   input  wire         reg_we_in,
   input  wire         unsigned_flag,

   // write-back
   output logic [31:0] reg_wdata,
   output logic        reg_we_out,
   output logic [4:0]  reg_rd,

   // UART transmit register
   output logic [31:0] uart_dout,
   output logic        uart_we
);

   logic [31:0] ram_rdata;
   logic        uart_sel;
   logic        uart_hit_r;

   mem_req_if req ();

   assign req.addr          = addr;
   assign req.size          = mem_types_pkg::access_size_e'(bytes);
   assign req.wdata         = wdata;
   assign req.we            = we;
   assign req.unsigned_flag = unsigned_flag;
   assign req.mem_to_reg    = mem_to_reg_in;

   byte_lane_ram u_ram (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .uart_sel  (uart_sel),
      .addr_b    (addr_b),
      .din_b     (din_b),
      .we_b      (we_b),
      .oe_b      (oe_b),
      .ram_rdata (ram_rdata),
      .dout_b    (dout_b)
   );

   mmio_uart_port u_uart (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .uart_sel   (uart_sel),
      .uart_hit_r (uart_hit_r),
      .uart_dout  (uart_dout),
      .uart_we    (uart_we)
   );

   load_writeback u_wb (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .req        (req),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .alu_result (alu_result),
      .ram_rdata  (ram_rdata),
      .uart_hit_r (uart_hit_r),
      .reg_wdata  (reg_wdata),
      .reg_we_out (reg_we_out),
      .reg_rd     (reg_rd)
   );

endmodule

`default_nettype wire

// ==== testbench/data_memory_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_macros.svh"

module data_memory_chk (
   input wire        clk,
   input wire        rst,
   input wire        run,
   input wire        we,
   input wire [31:0] addr,
   input wire        uart_we,
   input wire        reg_we_out
);

   int unsigned fail_count = 0;
   logic        uart_store;

   assign uart_store = we && (addr == `DMEM_UART_ADDR);

   a_uart_single: assert property (@(posedge clk) disable iff (rst)
      uart_we && $past(uart_we) |-> $past(uart_store) && $past(uart_store, 2))
      else begin
         fail_count++;
         $error("uart_we held two cycles without two UART stores in a row");
      end

   a_run_gate: assert property (@(posedge clk) disable iff (rst) !run |=> !reg_we_out)
      else begin
         fail_count++;
         $error("reg_we_out high after a cycle with run low");
      end

   a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !uart_we && !reg_we_out)
      else begin
         fail_count++;
         $error("uart_we or reg_we_out high right after reset");
      end

endmodule

bind data_memory data_memory_chk u_chk (
   .clk        (clk),
   .rst        (rst),
   .run        (run),
   .we         (we),
   .addr       (addr),
   .uart_we    (uart_we),
   .reg_we_out (reg_we_out)
);

`default_nettype wire

// ==== testbench/data_memory_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory_monitor (
   input  wire         clk,
   input  wire         rst,
   input  wire  [3:0]  chk_mask,
   input  wire  [31:0] exp_dout_b,
   input  wire  [31:0] exp_reg_wdata,
   input  wire  [7:0]  exp_wb,
   input  wire         exp_uart_we,
   input  wire  [31:0] exp_uart_dout,
   input  wire  [31:0] dout_b,
   input  wire  [31:0] reg_wdata,
   input  wire         reg_we_out,
   input  wire  [4:0]  reg_rd,
   input  wire         uart_we,
   input  wire  [31:0] uart_dout,
   output logic        busy,
   output int unsigned error_count,
   output int unsigned check_count
);

   // expectations of the previous line, due after the edge that ended it
   logic [3:0]  mask_q;
   logic [31:0] dout_b_q;
   logic [31:0] reg_wdata_q;
   logic [7:0]  wb_q;
   logic        uart_we_q;
   logic [31:0] uart_dout_q;

   initial begin
      mask_q      = '0;
      error_count = 0;
      check_count = 0;
   end

   assign busy = (mask_q != 4'b0000);

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   always @(posedge clk) begin
      if (mask_q[3])
         compare("dout_b", dout_b_q, dout_b);
      if (mask_q[2])
         compare("reg_wdata", reg_wdata_q, reg_wdata);
      if (mask_q[1]) begin
         compare("reg_we_out", {31'b0, wb_q[7]}, {31'b0, reg_we_out});
         compare("reg_rd", {27'b0, wb_q[4:0]}, {27'b0, reg_rd});
      end
      if (mask_q[0]) begin
         compare("uart_we", {31'b0, uart_we_q}, {31'b0, uart_we});
         compare("uart_dout", uart_dout_q, uart_dout);
      end
      mask_q      <= rst ? 4'b0000 : chk_mask;
      dout_b_q    <= exp_dout_b;
      reg_wdata_q <= exp_reg_wdata;
      wb_q        <= exp_wb;
      uart_we_q   <= exp_uart_we;
      uart_dout_q <= exp_uart_dout;
   end

endmodule

`default_nettype wire

// ==== testbench/data_memory_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory_tb;

   localparam int MAX_LINES     = 64;
   localparam int RESET_CYCLES  = 10;
   localparam int DRAIN_TIMEOUT = 20;

   logic        clk;
   logic        rst;
   logic        run;
   logic [31:0] addr_b;
   logic [31:0] din_b;
   logic        we_b;
   logic        oe_b;
   logic [31:0] addr;
   logic [1:0]  bytes;
   logic [31:0] wdata;
   logic        we;
   logic        mem_to_reg_in;
   logic [31:0] alu_result;
   logic [4:0]  rd_in;
   logic        reg_we_in;
   logic        unsigned_flag;

   wire  [31:0] dout_b;
   wire  [31:0] reg_wdata;
   wire         reg_we_out;
   wire  [4:0]  reg_rd;
   wire  [31:0] uart_dout;
   wire         uart_we;

   // expected values for the line now applied
   logic [3:0]  chk_mask;
   logic [31:0] exp_dout_b;
   logic [31:0] exp_reg_wdata;
   logic [7:0]  exp_wb;
   logic        exp_uart_we;
   logic [31:0] exp_uart_dout;

   wire         busy;
   int unsigned error_count;
   int unsigned check_count;

   logic [287:0] patterns [MAX_LINES];

   data_memory uut (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .addr_b        (addr_b),
      .din_b         (din_b),
      .we_b          (we_b),
      .oe_b          (oe_b),
      .dout_b        (dout_b),
      .addr          (addr),
      .bytes         (bytes),
      .wdata         (wdata),
      .we            (we),
      .mem_to_reg_in (mem_to_reg_in),
      .alu_result    (alu_result),
      .rd_in         (rd_in),
      .reg_we_in     (reg_we_in),
      .unsigned_flag (unsigned_flag),
      .reg_wdata     (reg_wdata),
      .reg_we_out    (reg_we_out),
      .reg_rd        (reg_rd),
      .uart_dout     (uart_dout),
      .uart_we       (uart_we)
   );

   data_memory_monitor u_mon (
      .clk           (clk),
      .rst           (rst),
      .chk_mask      (chk_mask),
      .exp_dout_b    (exp_dout_b),
      .exp_reg_wdata (exp_reg_wdata),
      .exp_wb        (exp_wb),
      .exp_uart_we   (exp_uart_we),
      .exp_uart_dout (exp_uart_dout),
      .dout_b        (dout_b),
      .reg_wdata     (reg_wdata),
      .reg_we_out    (reg_we_out),
      .reg_rd        (reg_rd),
      .uart_we       (uart_we),
      .uart_dout     (uart_dout),
      .busy          (busy),
      .error_count   (error_count),
      .check_count   (check_count)
   );

   always #50 clk = ~clk;

   // unpack one pattern line onto the DUT inputs and the expected fields
   task automatic apply_line(input logic [287:0] p);
      addr_b        = p[287:256];
      din_b         = p[255:224];
      we_b          = p[223];
      oe_b          = p[222];
      we            = p[221];
      mem_to_reg_in = p[220];
      addr          = p[219:188];
      bytes         = p[187:186];
      unsigned_flag = p[185];
      run           = p[184];
      wdata         = p[183:152];
      alu_result    = p[151:120];
      reg_we_in     = p[119];
      rd_in         = p[116:112];
      chk_mask      = p[111:108];
      exp_dout_b    = p[107:76];
      exp_reg_wdata = p[75:44];
      exp_wb        = p[43:36];
      exp_uart_we   = p[32];
      exp_uart_dout = p[31:0];
   endtask

   initial begin
      int          num_lines;
      int          drain;
      int unsigned assert_fails;
      logic        timed_out;
      clk       = 1'b0;
      rst       = 1'b1;
      timed_out = 1'b0;
      apply_line('0);
      for (int i = 0; i < MAX_LINES; i++)
         patterns[i] = 'x;
      $readmemh("testbench/dmem_patterns.txt", patterns);
      num_lines = 0;
      while (num_lines < MAX_LINES && !$isunknown(patterns[num_lines]))
         num_lines++;
      if (num_lines == 0)
         $display("no pattern lines could be read from the data file");

      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;

      for (int i = 0; i < num_lines; i++) begin
         @(posedge clk);
         #1 apply_line(patterns[i]);
      end
      @(posedge clk);
      #1 apply_line('0);   // idle, nothing checked

      drain = 0;
      while (busy && drain < DRAIN_TIMEOUT) begin
         @(posedge clk);
         #1 drain++;
      end
      if (busy) begin
         timed_out = 1'b1;
         $display("timeout: monitor still waiting on a pattern after %0d cycles", drain);
      end

      assert_fails = uut.u_chk.fail_count;
      $display("%0d lines, %0d checks, %0d compare errors, %0d assertion failures",
               num_lines, check_count, error_count, assert_fails);
      if (!timed_out && num_lines > 0 && error_count == 0 && assert_fails == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/dmem_patterns.txt ====
// addr_b din_b {we_b,oe_b,we,m2r} addr {bytes,uns,run} wdata alu {reg_we,00,rd}
// mask{dout_b,reg_wdata,we/rd,uart} exp_dout_b exp_reg_wdata exp_{we,rd} exp_uart_we exp_uart_dout
// port B word round trip
00000100_8badf00d_8_00000000_1_00000000_00000000_00_2_00000000_00000000_00_0_00000000
00000104_12345678_8_00000000_1_00000000_00000000_00_2_00000000_00000000_00_0_00000000
00000100_00000000_4_00000000_1_00000000_00000000_00_8_8badf00d_00000000_00_0_00000000
00000104_00000000_4_00000000_1_00000000_00000000_00_8_12345678_00000000_00_0_00000000
// pipeline stores of each size, each read back by a word load
00000108_a1b2c3d4_8_00000000_1_00000000_00000000_00_2_00000000_00000000_00_0_00000000
00000000_00000000_2_00000109_5_ffffffee_00000000_00_2_00000000_00000000_00_0_00000000
00000000_00000000_1_00000108_1_00000000_00000000_81_6_00000000_a1b2eed4_81_0_00000000
00000000_00000000_2_0000010a_9_12345566_00000000_00_2_00000000_00000000_00_0_00000000
00000000_00000000_1_00000108_1_00000000_00000000_82_6_00000000_5566eed4_82_0_00000000
00000000_00000000_2_0000010b_5_00000077_00000000_00_0_00000000_00000000_00_0_00000000
00000000_00000000_2_00000108_5_00000099_00000000_00_0_00000000_00000000_00_0_00000000
00000000_00000000_1_00000108_1_00000000_00000000_83_6_00000000_7766ee99_83_0_00000000
00000000_00000000_2_00000108_9_0000abcd_00000000_00_0_00000000_00000000_00_0_00000000
00000000_00000000_1_00000108_1_00000000_00000000_84_6_00000000_7766abcd_84_0_00000000
// loads of each size and offset, signed and unsigned
0000010c_f08a7c85_8_00000000_1_00000000_00000000_00_2_00000000_00000000_00_0_00000000
00000000_00000000_1_0000010c_5_00000000_00000000_85_6_00000000_ffffff85_85_0_00000000
00000000_00000000_1_0000010c_7_00000000_00000000_86_6_00000000_00000085_86_0_00000000
00000000_00000000_1_0000010d_5_00000000_00000000_87_6_00000000_0000007c_87_0_00000000
00000000_00000000_1_0000010e_5_00000000_00000000_88_6_00000000_ffffff8a_88_0_00000000
00000000_00000000_1_0000010e_7_00000000_00000000_89_6_00000000_0000008a_89_0_00000000
00000000_00000000_1_0000010f_5_00000000_00000000_8a_6_00000000_fffffff0_8a_0_00000000
00000000_00000000_1_0000010f_7_00000000_00000000_8b_6_00000000_000000f0_8b_0_00000000
00000000_00000000_1_0000010c_9_00000000_00000000_8c_6_00000000_00007c85_8c_0_00000000
00000000_00000000_1_0000010e_9_00000000_00000000_8d_6_00000000_fffff08a_8d_0_00000000
00000000_00000000_1_0000010e_b_00000000_00000000_8e_6_00000000_0000f08a_8e_0_00000000
00000000_00000000_1_0000010c_1_00000000_00000000_8f_6_00000000_f08a7c85_8f_0_00000000
// ALU write-back and run gating
00000000_00000000_0_00000000_1_00000000_deadbeef_9f_6_00000000_deadbeef_9f_0_00000000
00000000_00000000_0_00000000_0_00000000_cafe0001_8a_6_00000000_cafe0001_0a_0_00000000
00000000_00000000_0_00000000_1_00000000_00000042_03_6_00000000_00000042_03_0_00000000
// UART store, load from UART, RAM word left alone
00000000_5a5a5a5a_8_00000000_1_00000000_00000000_00_0_00000000_00000000_00_0_00000000
00000000_00000000_2_10000000_1_13572468_00000000_00_1_00000000_00000000_00_1_13572468
00000000_00000000_2_10000000_5_123456ab_00000000_00_1_00000000_00000000_00_1_000000ab
00000000_00000000_1_10000000_1_00000000_00000000_84_7_00000000_00000000_84_0_000000ab
00000000_00000000_4_00000000_1_00000000_00000000_00_9_5a5a5a5a_00000000_00_0_000000ab
// pipeline store and port B write in one cycle
00000114_0badcafe_8_00000000_1_00000000_00000000_00_0_00000000_00000000_00_0_00000000
00000114_33334444_a_00000110_1_11112222_00000000_00_0_00000000_00000000_00_0_00000000
00000110_00000000_4_00000000_1_00000000_00000000_00_8_11112222_00000000_00_0_00000000
00000114_00000000_4_00000000_1_00000000_00000000_00_8_0badcafe_00000000_00_0_00000000
00000000_00000000_0_00000000_1_00000000_00000000_00_7_00000000_00000000_00_0_000000ab

// ==== flist.f ====
+incdir+logic
logic/mem_types_pkg.sv
logic/wb_types_pkg.sv
logic/mem_req_if.sv
logic/simple_dualportram.sv
logic/byte_lane_ram.sv
logic/mmio_uart_port.sv
logic/load_writeback.sv
logic/data_memory.sv
testbench/data_memory_chk.sv
testbench/data_memory_monitor.sv
testbench/data_memory_tb.sv
